// ==== blur_params.svh ====
// Frame size, FIFO depth and divider width shared by the blur package and RTL, include anywhere
`ifndef BLUR_PARAMS_SVH
`define BLUR_PARAMS_SVH

// Frame width in pixels
`define BLUR_WIDTH 16

// Frame height in lines
`define BLUR_HEIGHT 8

// Entries in each pixel FIFO
`define BLUR_FIFO_DEPTH 16

// Dividend and quotient width
// Covers a full-kernel sum of 255 * 159
`define BLUR_NUM_WIDTH 16

`endif

// ==== blur_pkg.sv ====
// Shared types of the Gaussian blur datapath and control, imported by every blur module
`include "blur_params.svh"

package blur_pkg;

    // One grayscale pixel
    typedef logic [7:0] pixel_t;

    // Numerator into the divider and quotient out of it
    typedef logic [`BLUR_NUM_WIDTH-1:0] num_t;

    // Sum of in-frame kernel weights, 159 at most
    typedef logic [7:0] weight_t;

    // 5x5 window, row-major, index 0 is the top-left tap
    typedef pixel_t [24:0] window_t;

    // Frame position of the window centre
    typedef struct packed {
        logic [$clog2(`BLUR_HEIGHT)-1:0] row;
        logic [$clog2(`BLUR_WIDTH)-1:0]  col;
    } blur_pos_t;

    // Control phases for one output pixel
    typedef enum logic [2:0] {
        PROLOGUE,
        FILTER,
        ACCUMULATE,
        DIVIDE,
        OUTPUT
    } blur_state_t;

endpackage

// ==== pixel_fifo.sv ====
// Synchronous first-word-fall-through pixel FIFO, used on both the input and output streams
`timescale 1ns/10ps
`include "blur_params.svh"

module pixel_fifo (
    input  logic             clock,
    input  logic             reset,
    input  logic             wr_en,
    input  blur_pkg::pixel_t din,
    output logic             full,
    input  logic             rd_en,
    output blur_pkg::pixel_t dout,
    output logic             empty
);
    import blur_pkg::*;

    localparam int DEPTH = `BLUR_FIFO_DEPTH;
    localparam int AW = $clog2(DEPTH);

    pixel_t        mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          do_wr;
    logic          do_rd;

    assign full  = (count == DEPTH);
    assign empty = (count == 0);
    // Writes into a full FIFO are dropped, reads from an empty one ignored
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;
    // Head entry is always visible
    assign dout  = mem[rd_ptr];

    always_ff @(posedge clock) begin
        if (do_wr) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Pointers wrap at DEPTH, so any depth works
            if (do_wr) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// ==== window_shift_reg.sv ====
// Four-line-plus-five pixel shift register that forms the 5x5 blur window
`timescale 1ns/10ps
`include "blur_params.svh"

module window_shift_reg (
    input  logic              clock,
    input  logic              reset,
    input  logic              shift,
    input  logic              pad,
    input  blur_pkg::pixel_t  pixel_in,
    output blur_pkg::window_t window
);
    import blur_pkg::*;

    localparam int W = `BLUR_WIDTH;
    localparam int LEN = 4 * W + 5;

    // Index 0 holds the oldest pixel, LEN-1 the newest
    pixel_t [0:LEN-1] taps;
    pixel_t           next_pixel;

    // Zeros once the frame's real pixels are all in
    assign next_pixel = pad ? '0 : pixel_in;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            taps <= '0;
        end else if (shift) begin
            taps <= {taps[1:LEN-1], next_pixel};
        end
    end

    // Five taps from each of five lines, one line apart
    // Centre of the window sits at 2*W+2
    always_comb begin
        for (int r = 0; r < 5; r++) begin
            for (int c = 0; c < 5; c++) begin
                window[r*5+c] = taps[r*W+c];
            end
        end
    end

endmodule

// ==== gaussian_mac.sv ====
// Border-masked 5x5 Gaussian multiply-accumulate producing the numerator and weight sum
`timescale 1ns/10ps
`include "blur_params.svh"

module gaussian_mac (
    input  logic                clock,
    input  logic                reset,
    input  logic                load,
    input  blur_pkg::blur_pos_t pos,
    input  blur_pkg::window_t   window,
    input  logic                sum_en,
    output blur_pkg::num_t      num,
    output blur_pkg::weight_t   den
);
    import blur_pkg::*;

    // Fixed kernel, weights add up to 159
    localparam weight_t KERNEL [5][5] = '{
        '{8'd2, 8'd4,  8'd5,  8'd4,  8'd2},
        '{8'd4, 8'd9,  8'd12, 8'd9,  8'd4},
        '{8'd5, 8'd12, 8'd15, 8'd12, 8'd5},
        '{8'd4, 8'd9,  8'd12, 8'd9,  8'd4},
        '{8'd2, 8'd4,  8'd5,  8'd4,  8'd2}
    };

    logic [4:0] row_ok;
    logic [4:0] col_ok;
    num_t       col_num   [5];
    num_t       col_num_c [5];
    weight_t    col_den   [5];
    weight_t    col_den_c [5];
    num_t       num_c;
    weight_t    den_c;

    // Which window rows and columns land inside the frame
    always_comb begin
        for (int k = 0; k < 5; k++) begin
            row_ok[k] = (int'(pos.row) + k >= 2) && (int'(pos.row) + k - 2 < `BLUR_HEIGHT);
            col_ok[k] = (int'(pos.col) + k >= 2) && (int'(pos.col) + k - 2 < `BLUR_WIDTH);
        end
    end

    // One partial per window column, five products each
    always_comb begin
        for (int c = 0; c < 5; c++) begin
            col_num_c[c] = '0;
            col_den_c[c] = '0;
            for (int r = 0; r < 5; r++) begin
                // Taps outside the frame drop out of both sums
                if (row_ok[r] && col_ok[c]) begin
                    col_num_c[c] = col_num_c[c] + num_t'(window[r*5+c]) * num_t'(KERNEL[r][c]);
                    col_den_c[c] = col_den_c[c] + KERNEL[r][c];
                end
            end
        end
    end

    // Final adder over the registered partials
    always_comb begin
        num_c = '0;
        den_c = '0;
        for (int k = 0; k < 5; k++) begin
            num_c = num_c + col_num[k];
            den_c = den_c + col_den[k];
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            col_num <= '{default: '0};
            col_den <= '{default: '0};
            num     <= '0;
            den     <= '0;
        end else begin
            if (load) begin
                col_num <= col_num_c;
                col_den <= col_den_c;
            end
            if (sum_en) begin
                num <= num_c;
                den <= den_c;
            end
        end
    end

endmodule

// ==== div_unsigned.sv ====
// Restoring shift-subtract divider, one quotient bit per cycle, result held until next start
`timescale 1ns/10ps
`include "blur_params.svh"

module div_unsigned (
    input  logic              clock,
    input  logic              reset,
    input  logic              start,
    input  blur_pkg::num_t    dividend,
    input  blur_pkg::weight_t divisor,
    output logic              busy,
    output blur_pkg::num_t    quotient
);
    import blur_pkg::*;

    localparam int N = `BLUR_NUM_WIDTH;
    localparam int CW = $clog2(N + 1);
    localparam logic [CW-1:0] STEPS = CW'(N);

    logic [CW-1:0]          count;
    num_t                   quo;
    weight_t                rem;
    weight_t                dsor;
    logic [$bits(weight_t):0] trial;
    logic [$bits(weight_t):0] diff;

    // Partial remainder with the next dividend bit shifted in
    assign trial = {rem, quo[N-1]};
    // Top bit set means the subtraction borrowed
    assign diff = trial - {1'b0, dsor};
    assign busy = (count != '0);
    // Dividend bits leave the top as quotient bits enter the bottom
    assign quotient = quo;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            count <= '0;
        end else if (start) begin
            count <= STEPS;
        end else if (busy) begin
            count <= count - 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (start) begin
            quo  <= dividend;
            rem  <= '0;
            dsor <= divisor;
        end else if (busy) begin
            if (!diff[$bits(weight_t)]) begin
                rem <= diff[$bits(weight_t)-1:0];
                quo <= {quo[N-2:0], 1'b1};
            end else begin
                // Restore, keep the shifted remainder
                rem <= trial[$bits(weight_t)-1:0];
                quo <= {quo[N-2:0], 1'b0};
            end
        end
    end

endmodule

// ==== blur_control.sv ====
// Blur control FSM sequencing window fill, MAC, divider and output FIFO writes per pixel
`timescale 1ns/10ps
`include "blur_params.svh"

module blur_control (
    input  logic                clock,
    input  logic                reset,
    input  logic                in_empty,
    output logic                in_rd_en,
    output logic                shift,
    output logic                pad,
    output logic                load,
    output blur_pkg::blur_pos_t pos,
    output logic                sum_en,
    output logic                start,
    input  logic                busy,
    input  blur_pkg::num_t      quotient,
    input  logic                out_full,
    output logic                out_wr_en,
    output blur_pkg::pixel_t    out_pixel
);
    import blur_pkg::*;

    localparam int PIXELS = `BLUR_WIDTH * `BLUR_HEIGHT;
    // Shifts needed to bring pixel 0 to the window centre
    localparam int FILL = 2 * `BLUR_WIDTH + 3;

    blur_state_t                 state;
    blur_state_t                 state_c;
    logic [$clog2(FILL)-1:0]     fill_cnt;
    logic [$clog2(FILL)-1:0]     fill_cnt_c;
    logic [$clog2(PIXELS+1)-1:0] in_cnt;
    logic [$clog2(PIXELS+1)-1:0] in_cnt_c;
    blur_pos_t                   pos_c;
    logic                        advance;

    // All real pixels shifted in, zeros from here to the frame end
    assign pad       = (in_cnt == PIXELS);
    assign advance   = pad || !in_empty;
    // FIFO pops only for real pixels
    assign in_rd_en  = shift && !pad;
    assign load      = (state == FILTER) && advance;
    assign sum_en    = (state == ACCUMULATE);
    // Normalised average never exceeds 255
    assign out_pixel = quotient[7:0];

    always_comb begin
        state_c    = state;
        fill_cnt_c = fill_cnt;
        in_cnt_c   = in_cnt;
        pos_c      = pos;
        shift      = 1'b0;
        out_wr_en  = 1'b0;
        case (state)
            PROLOGUE: begin
                // Prologue never runs into padding since a frame is larger than FILL
                if (!in_empty) begin
                    shift    = 1'b1;
                    in_cnt_c = in_cnt + 1'b1;
                    if (fill_cnt == FILL - 1) begin
                        fill_cnt_c = '0;
                        state_c    = FILTER;
                    end else begin
                        fill_cnt_c = fill_cnt + 1'b1;
                    end
                end
            end
            FILTER: begin
                // MAC takes the current window as it shifts
                if (advance) begin
                    shift = 1'b1;
                    if (!pad) begin
                        in_cnt_c = in_cnt + 1'b1;
                    end
                    state_c = ACCUMULATE;
                end
            end
            ACCUMULATE: begin
                state_c = DIVIDE;
            end
            DIVIDE: begin
                // Start cycle first, then wait out busy
                if (!start && !busy) begin
                    state_c = OUTPUT;
                end
            end
            OUTPUT: begin
                if (!out_full) begin
                    out_wr_en = 1'b1;
                    if (pos.row == `BLUR_HEIGHT - 1 && pos.col == `BLUR_WIDTH - 1) begin
                        // Frame done, next frame starts its own prologue
                        state_c    = PROLOGUE;
                        pos_c      = '0;
                        in_cnt_c   = '0;
                        fill_cnt_c = '0;
                    end else begin
                        state_c = FILTER;
                        if (pos.col == `BLUR_WIDTH - 1) begin
                            pos_c.col = '0;
                            pos_c.row = pos.row + 1'b1;
                        end else begin
                            pos_c.col = pos.col + 1'b1;
                        end
                    end
                end
            end
            default: begin
                state_c = PROLOGUE;
            end
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state    <= PROLOGUE;
            fill_cnt <= '0;
            in_cnt   <= '0;
            pos      <= '0;
            start    <= 1'b0;
        end else begin
            state    <= state_c;
            fill_cnt <= fill_cnt_c;
            in_cnt   <= in_cnt_c;
            pos      <= pos_c;
            // Divider launches once num and den are registered
            start    <= (state == ACCUMULATE);
        end
    end

endmodule

// ==== gaussian_blur_top.sv ====
// Top level of the streaming 5x5 Gaussian blur between an input and an output pixel FIFO
`timescale 1ns/10ps

module gaussian_blur_top (
    input  logic             clock,
    input  logic             reset,
    input  logic             in_wr_en,
    input  blur_pkg::pixel_t in_din,
    output logic             in_full,
    input  logic             out_rd_en,
    output blur_pkg::pixel_t out_dout,
    output logic             out_empty
);
    import blur_pkg::*;

    pixel_t    in_head;
    logic      in_empty;
    logic      in_rd_en;
    logic      shift;
    logic      pad;
    window_t   window;
    logic      load;
    blur_pos_t pos;
    logic      sum_en;
    num_t      num;
    weight_t   den;
    logic      start;
    logic      busy;
    num_t      quotient;
    logic      out_full;
    logic      out_wr_en;
    pixel_t    out_pixel;

    // Source side, raster-order pixels
    pixel_fifo in_fifo_i (
        .clock (clock),
        .reset (reset),
        .wr_en (in_wr_en),
        .din   (in_din),
        .full  (in_full),
        .rd_en (in_rd_en),
        .dout  (in_head),
        .empty (in_empty)
    );

    window_shift_reg window_i (
        .clock    (clock),
        .reset    (reset),
        .shift    (shift),
        .pad      (pad),
        .pixel_in (in_head),
        .window   (window)
    );

    gaussian_mac mac_i (
        .clock  (clock),
        .reset  (reset),
        .load   (load),
        .pos    (pos),
        .window (window),
        .sum_en (sum_en),
        .num    (num),
        .den    (den)
    );

    div_unsigned div_i (
        .clock    (clock),
        .reset    (reset),
        .start    (start),
        .dividend (num),
        .divisor  (den),
        .busy     (busy),
        .quotient (quotient)
    );

    blur_control ctrl_i (
        .clock     (clock),
        .reset     (reset),
        .in_empty  (in_empty),
        .in_rd_en  (in_rd_en),
        .shift     (shift),
        .pad       (pad),
        .load      (load),
        .pos       (pos),
        .sum_en    (sum_en),
        .start     (start),
        .busy      (busy),
        .quotient  (quotient),
        .out_full  (out_full),
        .out_wr_en (out_wr_en),
        .out_pixel (out_pixel)
    );

    // Sink side, blurred pixels in raster order
    pixel_fifo out_fifo_i (
        .clock (clock),
        .reset (reset),
        .wr_en (out_wr_en),
        .din   (out_pixel),
        .full  (out_full),
        .rd_en (out_rd_en),
        .dout  (out_dout),
        .empty (out_empty)
    );

endmodule

// ==== tb_clock_gen.sv ====
// Testbench clock and reset source for the blur testbench, 40 ns clock and 16-cycle reset
`timescale 1ns/10ps

module tb_clock_gen (
    output logic clock,
    output logic reset
);
    localparam time HALF_PERIOD = 20ns;
    localparam int RESET_CYCLES = 16;

    // Free-running clock, the testbench ends the run
    initial begin
        clock = 1'b0;
        forever #(HALF_PERIOD) clock = ~clock;
    end

    // Reset held from time zero, released just after an edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clock);
        #2;
        reset = 1'b0;
    end

endmodule

// ==== tb_blur_checker.sv ====
// Blur output checker that builds expected pixels from each input frame and compares every pop
`timescale 1ns/10ps
`include "blur_params.svh"

module tb_blur_checker (
    input  logic             clock,
    input  logic             reset,
    input  logic             out_rd_en,
    input  blur_pkg::pixel_t out_dout,
    input  logic             out_empty,
    output int               checked,
    output int               mismatches,
    output int               other_errors,
    output int               pending
);
    import blur_pkg::*;

    localparam int W = `BLUR_WIDTH;
    localparam int H = `BLUR_HEIGHT;
    localparam int PIXELS = W * H;

    // Gaussian kernel in row-major order with the top-left weight at index 0
    localparam logic [0:24][7:0] KERNEL = {
        8'd2, 8'd4,  8'd5,  8'd4,  8'd2,
        8'd4, 8'd9,  8'd12, 8'd9,  8'd4,
        8'd5, 8'd12, 8'd15, 8'd12, 8'd5,
        8'd4, 8'd9,  8'd12, 8'd9,  8'd4,
        8'd2, 8'd4,  8'd5,  8'd4,  8'd2
    };

    pixel_t frame_buf [$];
    pixel_t img [PIXELS];
    int     expect_q [$];
    int     index_q [$];
    int     check_count = 0;
    int     mismatch_count = 0;
    int     other_count = 0;
    int     added_count = 0;
    int     popped_count = 0;
    int     exp_val;
    int     exp_idx;

    assign checked      = check_count;
    assign mismatches   = mismatch_count;
    assign other_errors = other_count;
    assign pending      = added_count - popped_count;

    // Weighted average over the taps that fall inside the frame
    function automatic int blur_reference(input int row, input int col);
        int num;
        int den;
        int wt;
        num = 0;
        den = 0;
        for (int dr = -2; dr <= 2; dr++) begin
            for (int dc = -2; dc <= 2; dc++) begin
                if (row + dr >= 0 && row + dr < H && col + dc >= 0 && col + dc < W) begin
                    wt  = int'(KERNEL[(dr + 2) * 5 + dc + 2]);
                    num = num + wt * int'(img[(row + dr) * W + col + dc]);
                    den = den + wt;
                end
            end
        end
        // Positive operands make this division the floor
        return num / den;
    endfunction

    // Called by the testbench for every pixel it is about to send
    task automatic add_pixel(input pixel_t p);
        frame_buf.push_back(p);
        added_count++;
        if (frame_buf.size() == PIXELS) begin
            for (int i = 0; i < PIXELS; i++) begin
                img[i] = frame_buf[i];
            end
            frame_buf.delete();
            // Expected values queued in raster order like the DUT output
            for (int i = 0; i < PIXELS; i++) begin
                expect_q.push_back(blur_reference(i / W, i % W));
                index_q.push_back(i);
            end
        end
    endtask

    // A pop happens on an edge with rd_en high and the FIFO not empty
    always @(posedge clock) begin
        if (!reset && out_rd_en && !out_empty) begin
            popped_count++;
            if (expect_q.size() == 0) begin
                $display("Time %0d ns: pixel value %0d popped with no expected value left",
                         $time, out_dout);
                other_count++;
            end else begin
                exp_val = expect_q.pop_front();
                exp_idx = index_q.pop_front();
                check_count++;
                if (int'(out_dout) != exp_val) begin
                    $display({"Mismatch at %0d ns: out_dout expected %0d, got %0d",
                              " (row %0d col %0d)"},
                             $time, exp_val, out_dout, exp_idx / W, exp_idx % W);
                    mismatch_count++;
                end
            end
        end
    end

endmodule

// ==== tb_gaussian_blur.sv ====
// Testbench top for the Gaussian blur that sends frames, drains results and prints the verdict
`timescale 1ns/10ps
`include "blur_params.svh"

module tb_gaussian_blur;
    import blur_pkg::*;

    localparam int PIXELS = `BLUR_WIDTH * `BLUR_HEIGHT;
    localparam int RESET_TIMEOUT = 100;
    localparam int FULL_TIMEOUT = 1000;
    localparam int PIXEL_TIMEOUT = 1000;

    logic   clock;
    logic   reset;
    logic   in_wr_en;
    pixel_t in_din;
    logic   in_full;
    logic   out_rd_en;
    pixel_t out_dout;
    logic   out_empty;
    int     checked;
    int     mismatches;
    int     other_errors;
    int     pending;
    int     fail_count = 0;
    pixel_t stim_q [$];

    tb_clock_gen clock_i (
        .clock (clock),
        .reset (reset)
    );

    gaussian_blur_top dut_i (
        .clock     (clock),
        .reset     (reset),
        .in_wr_en  (in_wr_en),
        .in_din    (in_din),
        .in_full   (in_full),
        .out_rd_en (out_rd_en),
        .out_dout  (out_dout),
        .out_empty (out_empty)
    );

    tb_blur_checker check_i (
        .clock        (clock),
        .reset        (reset),
        .out_rd_en    (out_rd_en),
        .out_dout     (out_dout),
        .out_empty    (out_empty),
        .checked      (checked),
        .mismatches   (mismatches),
        .other_errors (other_errors),
        .pending      (pending)
    );

    // Inputs change 2 ns after the rising edge
    task automatic next_drive_slot();
        @(posedge clock);
        #2;
    endtask

    // Writes the queued pixels with random idle gaps while honouring in_full
    task automatic send_pixels(input int max_gap);
        int gap;
        int waited;
        while (stim_q.size() > 0) begin
            gap = (max_gap > 0) ? int'($urandom % (max_gap + 1)) : 0;
            in_wr_en = 1'b0;
            repeat (gap) next_drive_slot();
            waited = 0;
            while (in_full && waited < FULL_TIMEOUT) begin
                next_drive_slot();
                waited++;
            end
            if (in_full) begin
                $display("Time %0d ns: input FIFO stayed full for %0d cycles", $time, waited);
                fail_count++;
                stim_q.delete();
            end else begin
                in_wr_en = 1'b1;
                in_din   = stim_q.pop_front();
                next_drive_slot();
            end
        end
        in_wr_en = 1'b0;
    endtask

    // Pops count pixels with random stalls on the output side
    task automatic collect_pixels(input int count, input int max_stall, output int got);
        int stall;
        int waited;
        bit timed_out;
        got = 0;
        timed_out = 1'b0;
        while (got < count && !timed_out) begin
            out_rd_en = 1'b0;
            stall = (max_stall > 0) ? int'($urandom % (max_stall + 1)) : 0;
            repeat (stall) next_drive_slot();
            waited = 0;
            while (out_empty && waited < PIXEL_TIMEOUT) begin
                next_drive_slot();
                waited++;
            end
            if (out_empty) begin
                $display("Time %0d ns: no output pixel within %0d cycles, %0d of %0d received",
                         $time, waited, got, count);
                fail_count++;
                timed_out = 1'b1;
            end else begin
                out_rd_en = 1'b1;
                next_drive_slot();
                got++;
            end
        end
        out_rd_en = 1'b0;
    endtask

    // Output must stay empty while nothing is pending
    task automatic check_idle(input int cycles);
        bit seen;
        seen = 1'b0;
        for (int i = 0; i < cycles && !seen; i++) begin
            next_drive_slot();
            if (!out_empty) begin
                $display("Time %0d ns: output FIFO holds a pixel with no input pending", $time);
                fail_count++;
                seen = 1'b1;
            end
        end
    endtask

    // Negative level gives random frames and any other level a constant frame
    task automatic run_frames(input int frames, input int level, input int max_gap,
                              input int max_stall);
        int     got;
        pixel_t p;
        for (int f = 0; f < frames; f++) begin
            for (int i = 0; i < PIXELS; i++) begin
                p = (level < 0) ? pixel_t'($urandom) : pixel_t'(level);
                stim_q.push_back(p);
                check_i.add_pixel(p);
            end
        end
        fork
            send_pixels(max_gap);
            collect_pixels(frames * PIXELS, max_stall, got);
        join
        if (got != frames * PIXELS) begin
            $display("Time %0d ns: %0d frame(s) returned %0d of %0d pixels",
                     $time, frames, got, frames * PIXELS);
            fail_count++;
        end
        check_idle(40);
    endtask

    initial begin : stimulus
        int waited;
        in_wr_en  = 1'b0;
        in_din    = '0;
        out_rd_en = 1'b0;
        void'($urandom(32'h5411));
        waited = 0;
        while (reset && waited < RESET_TIMEOUT) begin
            @(posedge clock);
            waited++;
        end
        if (reset) begin
            $display("Reset was not released within %0d cycles", RESET_TIMEOUT);
            fail_count++;
        end
        next_drive_slot();
        // Idle state after reset
        if (out_empty !== 1'b1) begin
            $display("Mismatch at %0d ns: out_empty expected 1, got %b", $time, out_empty);
            fail_count++;
        end
        if (in_full !== 1'b0) begin
            $display("Mismatch at %0d ns: in_full expected 0, got %b", $time, in_full);
            fail_count++;
        end
        check_idle(100);
        // Random frame without gaps or stalls
        run_frames(1, -1, 0, 0);
        // Constant full-scale frame must come back unchanged
        run_frames(1, 255, 0, 0);
        // Long output stalls push back on the input side
        run_frames(1, -1, 0, 80);
        // Input gaps that also span the padding phase
        run_frames(1, -1, 6, 4);
        // Three frames back to back without a reset between them
        run_frames(3, -1, 3, 20);
        if (pending != 0) begin
            $display("%0d expected pixels never came out", pending);
            fail_count++;
        end
        $display("Summary: %0d pixels checked, %0d mismatches, %0d other failures",
                 checked, mismatches, other_errors + fail_count);
        if (mismatches == 0 && other_errors == 0 && fail_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+.
blur_pkg.sv
pixel_fifo.sv
window_shift_reg.sv
gaussian_mac.sv
div_unsigned.sv
blur_control.sv
gaussian_blur_top.sv
tb_clock_gen.sv
tb_blur_checker.sv
tb_gaussian_blur.sv

// ==== Bender.yml ====
package:
  name: gaussian_blur

sources:
  - include_dirs:
      - .
    files:
      - blur_pkg.sv
      - pixel_fifo.sv
      - window_shift_reg.sv
      - gaussian_mac.sv
      - div_unsigned.sv
      - blur_control.sv
      - gaussian_blur_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clock_gen.sv
      - tb_blur_checker.sv
      - tb_gaussian_blur.sv
